/* source/fetch_pkg.sv */
package fetch_pkg;

    // basic widths of the fetch path
    typedef logic [31:0]  addr_t;   // byte address
    typedef logic [31:0]  inst_t;   // one instruction word
    typedef logic [63:0]  beat_t;   // one bmem burst beat
    typedef logic [255:0] line_t;   // one full cache line

    // line address, everything above the 5-bit line offset
    typedef logic [26:0]  tag_t;

    // fetch starts here after reset
    localparam addr_t RESET_PC = 32'h1eceb000;

    // four 64-bit beats fill one line
    localparam int BEATS_PER_LINE = 4;

    // eight instruction words per line
    localparam int WORDS_PER_LINE = 8;

    // entries per fetch queue
    localparam int QUEUE_DEPTH = 16;

    // queue pointer, one extra bit for the wrap
    typedef logic [$clog2(QUEUE_DEPTH):0] qptr_t;

endpackage

/* source/pc_gen.sv */
module pc_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_resp_i,
    input  logic             queue_room_i,   // two or more entries free
    input  logic             redirect_i,
    input  fetch_pkg::addr_t redirect_pc_i,
    output logic             fetch_req_o,
    output fetch_pkg::addr_t fetch_pc_o,
    output logic             enq_o
);
    import fetch_pkg::*;

    addr_t pc_q;
    logic  pending_q;   // request issued, response not yet seen
    logic  drop_q;      // next response is from before a redirect

    // a new request only once the last one has come back
    assign fetch_req_o = !pending_q && queue_room_i;
    assign fetch_pc_o  = pc_q;
    assign enq_o       = fetch_resp_i && !drop_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= RESET_PC;
            pending_q <= 1'b0;
            drop_q    <= 1'b0;
        end else begin
            if (fetch_req_o) begin
                pending_q <= 1'b1;
            end else if (fetch_resp_i) begin
                pending_q <= 1'b0;
            end

            if (redirect_i) begin
                pc_q <= redirect_pc_i;   // redirect beats the advance
                // a response still owed for the old pc must not reach the queues
                drop_q <= (pending_q && !fetch_resp_i) || fetch_req_o;
            end else if (fetch_resp_i) begin
                if (!drop_q) begin
                    pc_q <= pc_q + 32'd4;
                end
                drop_q <= 1'b0;   // stale response consumed, pc already at target
            end
        end
    end

    // redirect targets from decode have to stay word aligned
    pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        fetch_pc_o[1:0] == 2'b00
    ) else $error("fetch pc not word aligned: %h", fetch_pc_o);

endmodule

/* source/line_buffer.sv */
module line_buffer (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_req_i,
    input  fetch_pkg::addr_t fetch_pc_i,
    output logic             fetch_resp_o,
    output fetch_pkg::inst_t fetch_inst_o,
    output logic             fill_req_o,
    output fetch_pkg::addr_t fill_addr_o,
    input  fetch_pkg::line_t fill_line_i,
    input  logic             fill_done_i
);
    import fetch_pkg::*;

    logic  valid_q;     // line_q holds a real line
    tag_t  tag_q;
    line_t line_q;
    logic  filling_q;   // waiting on the burst adapter
    addr_t miss_pc_q;   // pc that missed, answered after the fill
    logic  resp_q;
    inst_t inst_q;
    tag_t  req_tag;
    logic  hit;

    // word picked by pc[4:2]
    function automatic inst_t select_word(line_t line, addr_t addr);
        logic [$clog2(WORDS_PER_LINE)-1:0] idx;
        idx = addr[2 +: $clog2(WORDS_PER_LINE)];
        return line[idx*$bits(inst_t) +: $bits(inst_t)];
    endfunction

    assign req_tag = fetch_pc_i[$bits(addr_t)-1 -: $bits(tag_t)];
    assign hit     = valid_q && (tag_q == req_tag);

    // miss goes straight out, adapter latches the address
    assign fill_req_o  = fetch_req_i && !hit;
    assign fill_addr_o = {req_tag, {($bits(addr_t) - $bits(tag_t)){1'b0}}};

    assign fetch_resp_o = resp_q;
    assign fetch_inst_o = inst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            filling_q <= 1'b0;
            resp_q    <= 1'b0;
        end else begin
            resp_q <= fetch_req_i && hit;   // hit answers next cycle
            if (fill_req_o) begin
                filling_q <= 1'b1;
            end
            if (fill_done_i) begin
                filling_q <= 1'b0;
                valid_q   <= 1'b1;
                resp_q    <= 1'b1;   // miss answers the cycle after fill_done
            end
        end
    end

    // line contents and the word being returned
    always_ff @(posedge clk) begin
        if (fetch_req_i && hit) begin
            inst_q <= select_word(line_q, fetch_pc_i);
        end
        if (fill_req_o) begin
            miss_pc_q <= fetch_pc_i;
        end
        if (fill_done_i) begin
            line_q <= fill_line_i;
            tag_q  <= miss_pc_q[$bits(addr_t)-1 -: $bits(tag_t)];
            inst_q <= select_word(fill_line_i, miss_pc_q);
        end
    end

    // pc_gen keeps one request in flight, so a fill never overlaps another
    one_fill: assert property (
        @(posedge clk) disable iff (rst)
        filling_q |-> !fill_req_o
    ) else $error("fill request while a fill is outstanding");

endmodule

/* source/burst_adapter.sv */
module burst_adapter (
    input  logic             clk,
    input  logic             rst,
    input  logic             fill_req_i,
    input  fetch_pkg::addr_t fill_addr_i,
    output fetch_pkg::line_t fill_line_o,
    output logic             fill_done_o,
    output fetch_pkg::addr_t bmem_addr_o,
    output logic             bmem_read_o,
    input  logic             bmem_ready_i,
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,   // waiting for bmem_ready
        COLLECT    // read issued, beats arriving
    } state_t;

    state_t                            state_q;
    logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_q;
    addr_t                             addr_q;
    line_t                             line_q;
    logic                              done_q;
    logic                              last_beat;

    // read pulses for one cycle, only while memory is ready
    assign bmem_read_o = (state_q == REQUEST) && bmem_ready_i;
    assign bmem_addr_o = addr_q;
    assign fill_line_o = line_q;
    assign fill_done_o = done_q;

    assign last_beat = (state_q == COLLECT) && bmem_rvalid_i
                       && (beat_cnt_q == $bits(beat_cnt_q)'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            beat_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= last_beat;   // line complete one cycle after beat four
            case (state_q)
                IDLE: begin
                    if (fill_req_i) begin
                        state_q <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (bmem_read_o) begin
                        state_q    <= COLLECT;
                        beat_cnt_q <= '0;
                    end
                end
                COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && fill_req_i) begin
            addr_q <= fill_addr_i;
        end
        // lowest beat first, shifted down so it ends in the low bits
        if (state_q == COLLECT && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

    // address comes from the line buffer and must be line aligned
    read_ok: assert property (
        @(posedge clk) disable iff (rst)
        bmem_read_o |-> (bmem_addr_o[4:0] == 5'd0)
    ) else $error("bmem read address not line aligned: %h", bmem_addr_o);

endmodule

/* source/fetch_queue.sv */
module fetch_queue #(
    parameter type payload_t = fetch_pkg::inst_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush_i,
    input  logic     enqueue_i,
    input  payload_t wdata_i,
    input  logic     dequeue_i,
    output payload_t rdata_o,
    output logic     full_o,
    output logic     room_o,    // at least two free
    output logic     empty_o
);
    import fetch_pkg::*;

    payload_t mem [QUEUE_DEPTH];
    qptr_t    wr_ptr_q;
    qptr_t    rd_ptr_q;
    qptr_t    used;
    logic     do_enq;
    logic     do_deq;

    assign used    = wr_ptr_q - rd_ptr_q;   // wrap bit makes this exact
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (used == qptr_t'(QUEUE_DEPTH));
    assign room_o  = (used <= qptr_t'(QUEUE_DEPTH - 2));

    assign do_enq = enqueue_i && !full_o;
    assign do_deq = dequeue_i && !empty_o;   // dequeue on empty ignored

    // oldest entry always on the output
    assign rdata_o = mem[rd_ptr_q[$clog2(QUEUE_DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // storage, a write under flush is simply forgotten
    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr_q[$clog2(QUEUE_DEPTH)-1:0]] <= wdata_i;
        end
    end

    // pc_gen stops at two free entries, so an in-flight response always fits
    no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        enqueue_i |-> !full_o
    ) else $error("enqueue into a full fetch queue");

endmodule

/* source/fetch_unit.sv */
module fetch_unit (
    input  logic             clk,
    input  logic             rst,

    // bmem request
    output fetch_pkg::addr_t bmem_addr_o,
    output logic             bmem_read_o,
    input  logic             bmem_ready_i,

    // bmem reply
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i,

    // decode side
    output fetch_pkg::inst_t inst_o,
    output fetch_pkg::addr_t pc_o,
    output logic             empty_o,
    input  logic             dequeue_i,
    input  logic             redirect_i,
    input  fetch_pkg::addr_t redirect_pc_i
);
    import fetch_pkg::*;

    logic  fetch_req;
    addr_t fetch_pc;
    logic  fetch_resp;
    inst_t fetch_inst;
    logic  fill_req;
    addr_t fill_addr;
    line_t fill_line;
    logic  fill_done;
    logic  enq;          // response that survives a redirect
    logic  queue_room;

    pc_gen pc_gen_inst (
        .clk           (clk),
        .rst           (rst),
        .fetch_resp_i  (fetch_resp),
        .queue_room_i  (queue_room),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_req_o   (fetch_req),
        .fetch_pc_o    (fetch_pc),
        .enq_o         (enq)
    );

    line_buffer line_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .fetch_req_i  (fetch_req),
        .fetch_pc_i   (fetch_pc),
        .fetch_resp_o (fetch_resp),
        .fetch_inst_o (fetch_inst),
        .fill_req_o   (fill_req),
        .fill_addr_o  (fill_addr),
        .fill_line_i  (fill_line),
        .fill_done_i  (fill_done)
    );

    burst_adapter burst_adapter_inst (
        .clk           (clk),
        .rst           (rst),
        .fill_req_i    (fill_req),
        .fill_addr_i   (fill_addr),
        .fill_line_o   (fill_line),
        .fill_done_o   (fill_done),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // instruction queue sets the pace for fetch and decode
    fetch_queue #(.payload_t(inst_t)) inst_queue (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (redirect_i),
        .enqueue_i (enq),
        .wdata_i   (fetch_inst),
        .dequeue_i (dequeue_i),
        .rdata_o   (inst_o),
        .full_o    (),
        .room_o    (queue_room),
        .empty_o   (empty_o)
    );

    // runs in lock step with inst_queue, so its flags are not needed
    fetch_queue #(.payload_t(addr_t)) pc_queue (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (redirect_i),
        .enqueue_i (enq),
        .wdata_i   (fetch_pc),
        .dequeue_i (dequeue_i),
        .rdata_o   (pc_o),
        .full_o    (),
        .room_o    (),
        .empty_o   ()
    );

endmodule

/* verification/bmem_model.sv */
module bmem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             read_i,
    input  fetch_pkg::addr_t addr_i,
    output logic             ready_o,
    output fetch_pkg::beat_t rdata_o,
    output logic             rvalid_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    logic  ready_q  = 1'b0;
    logic  rvalid_q = 1'b0;
    beat_t rdata_q  = '0;
    logic  busy_q   = 1'b0;   // burst still owed
    addr_t beat_addr_q;
    int    beats_left_q;

    assign ready_o  = ready_q;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    // memory content, every word derived from its own address
    function automatic inst_t mem_word(addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            ready_q      <= 1'b0;
            rvalid_q     <= 1'b0;
            busy_q       <= 1'b0;
            beats_left_q <= 0;
        end else begin
            rvalid_q <= 1'b0;
            if (read_i) begin
                busy_q       <= 1'b1;
                ready_q      <= 1'b0;   // one read outstanding at a time
                beat_addr_q  <= addr_i;
                beats_left_q <= BEATS_PER_LINE;
            end else if (busy_q) begin
                ready_q <= 1'b0;
                // random gaps between beats
                if (($urandom % 4) != 0) begin
                    rvalid_q     <= 1'b1;
                    rdata_q      <= {mem_word(beat_addr_q + 32'd4), mem_word(beat_addr_q)};
                    beat_addr_q  <= beat_addr_q + 32'd8;
                    beats_left_q <= beats_left_q - 1;
                    if (beats_left_q == 1) begin
                        busy_q <= 1'b0;
                    end
                end
            end else begin
                ready_q <= ($urandom % 3) != 0;   // idle, ready with gaps
            end
        end
    end

endmodule

/* verification/tb_fetch.sv */
module tb_fetch;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int STREAM_DEQ     = 64;
    localparam int RANDOM_DEQ     = 48;
    localparam int REDIRECT_DEQ   = 96;
    localparam int TOTAL_DEQ      = STREAM_DEQ + RANDOM_DEQ + REDIRECT_DEQ;
    localparam int CYCLES_PER_DEQ = 200;
    localparam int PAUSE_CYCLES   = 100;
    // fetch stalls at two free slots, the response in flight fills one of them
    localparam int HELD_ENTRIES   = QUEUE_DEPTH - 1;

    localparam int MODE_STREAM   = 0;
    localparam int MODE_RANDOM   = 1;
    localparam int MODE_REDIRECT = 2;

    logic  clk = 1'b0;
    logic  rst;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_ready;
    beat_t bmem_rdata;
    logic  bmem_rvalid;
    inst_t inst;
    addr_t pc;
    logic  empty;
    logic  dequeue;
    logic  redirect;
    addr_t redirect_pc;

    addr_t exp_pc;       // pc of the next entry decode should see
    int    deq_count;
    int    read_count;

    always #10 clk = ~clk;

    fetch_unit fetch_unit_inst (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .inst_o        (inst),
        .pc_o          (pc),
        .empty_o       (empty),
        .dequeue_i     (dequeue),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc)
    );

    bmem_model bmem_model_inst (
        .clk      (clk),
        .rst      (rst),
        .read_i   (bmem_read),
        .addr_i   (bmem_addr),
        .ready_o  (bmem_ready),
        .rdata_o  (bmem_rdata),
        .rvalid_o (bmem_rvalid)
    );

    function automatic inst_t expected_inst(addr_t addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    // lines covered by a straight run of fetches from the reset pc
    function automatic int lines_touched(int fetched);
        addr_t last_pc;
        last_pc = RESET_PC + addr_t'(4 * (fetched - 1));
        return int'(last_pc[31:5] - RESET_PC[31:5]) + 1;
    endfunction

    // half the targets stay in the line of the next expected pc
    function automatic addr_t pick_target();
        if (($urandom % 2) == 0) begin
            return {exp_pc[31:5], 3'($urandom % 8), 2'b00};
        end
        return $urandom & 32'hffff_fffc;
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: inst_o got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: pc_o got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: bmem reads got %0d expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // compares every dequeued pair and watches the bmem request side
    always @(posedge clk) begin
        if (rst) begin
            exp_pc     <= RESET_PC;
            deq_count  <= 0;
            read_count <= 0;
        end else begin
            if (bmem_read) begin
                check_flag(bmem_ready, 1'b1, "bmem read issued while not ready");
                check_flag(bmem_addr[4:0] == 5'd0, 1'b1, "bmem read address not line aligned");
                read_count <= read_count + 1;
            end
            if (redirect) begin
                exp_pc <= redirect_pc;   // both queues flushed at this edge
            end else if (dequeue && !empty) begin
                check_pc(pc, exp_pc);
                check_inst(inst, expected_inst(exp_pc));
                exp_pc    <= exp_pc + 32'd4;
                deq_count <= deq_count + 1;
            end
        end
    end

    task automatic run_dequeues(input int count, input int mode);
        int target;
        @(negedge clk);
        target = deq_count + count;
        while (deq_count < target) begin
            @(posedge clk);
            // redirect only after an idle cycle, so exp_pc is settled
            if (mode == MODE_REDIRECT && !dequeue && !redirect && ($urandom % 10) == 0) begin
                redirect    <= 1'b1;
                redirect_pc <= pick_target();
            end else begin
                redirect <= 1'b0;
                if (mode == MODE_STREAM) begin
                    dequeue <= 1'b1;
                end else begin
                    dequeue <= ($urandom % 2) == 0;
                end
            end
            @(negedge clk);
        end
        @(posedge clk);
        dequeue  <= 1'b0;
        redirect <= 1'b0;
    endtask

    // queue fills up, then the read count must match the lines fetched
    task automatic check_line_reuse();
        int expected;
        @(negedge clk);
        expected = lines_touched(deq_count + HELD_ENTRIES);
        while (read_count < expected) begin
            @(negedge clk);
        end
        repeat (PAUSE_CYCLES) @(negedge clk);   // no extra read may follow
        check_count(read_count, expected);
    endtask

    initial begin
        void'($urandom(32'ha15b_584a));
        rst         <= 1'b1;
        dequeue     <= 1'b0;
        redirect    <= 1'b0;
        redirect_pc <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(empty, 1'b1, "empty_o low right after reset");
        check_flag(bmem_read, 1'b0, "bmem_read_o high right after reset");

        run_dequeues(STREAM_DEQ, MODE_STREAM);
        check_line_reuse();
        run_dequeues(RANDOM_DEQ, MODE_RANDOM);
        run_dequeues(REDIRECT_DEQ, MODE_REDIRECT);

        $display("No errors");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + PAUSE_CYCLES + CYCLES_PER_DEQ * TOTAL_DEQ) @(posedge clk);
        $display("timeout: fetch did not deliver the planned dequeues in time");
        abort_run();
    end

endmodule

/* flist.f */
source/fetch_pkg.sv
source/pc_gen.sv
source/line_buffer.sv
source/burst_adapter.sv
source/fetch_queue.sv
source/fetch_unit.sv
verification/bmem_model.sv
verification/tb_fetch.sv

/* run.sh */
#!/bin/sh
# builds tb_fetch with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fetch -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"

# the testbench verdict comes from the log
if grep -q "Errors found" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation ended abnormally with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
